// ==== design/rename_macros.svh ====
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// Register file geometry
`define LREG_WIDTH     5
`define PREG_WIDTH     6
`define NUM_LREGS      32
`define NUM_PREGS      64

// Free list sizing, one slot per register not held by the table
`define FREE_DEPTH     (`NUM_PREGS - `NUM_LREGS)
`define FREE_CNT_WIDTH 7

// APB bus widths
`define APB_ADDR_WIDTH 8
`define APB_DATA_WIDTH 32

`endif

// ==== design/rename_pkg.sv ====
`default_nettype none

`include "rename_macros.svh"

package rename_pkg;

    ////////////////////////////////////////////////////////////
    // Register numbers
    ////////////////////////////////////////////////////////////

    // Logical register as named by the ISA
    typedef logic [`LREG_WIDTH-1:0] lreg_t;

    // Physical register in the shared register file
    typedef logic [`PREG_WIDTH-1:0] preg_t;

    ////////////////////////////////////////////////////////////
    // Commit slot from the ROB
    ////////////////////////////////////////////////////////////

    // One retiring instruction
    // need_to_wb clear means no destination register
    typedef struct packed {
        logic  valid;
        logic  need_to_wb;
        lreg_t lrd;
        preg_t prd;
    } commit_t;

endpackage

`default_nettype wire

// ==== design/apb_pkg.sv ====
`default_nettype none

`include "rename_macros.svh"

package apb_pkg;

    // Requester side of the bus
    typedef struct packed {
        logic                       psel;
        logic                       penable;
        logic                       pwrite;
        logic [`APB_ADDR_WIDTH-1:0] paddr;
        logic [`APB_DATA_WIDTH-1:0] pwdata;
    } apb_req_t;

    // Completer side of the bus
    typedef struct packed {
        logic                       pready;
        logic                       pslverr;
        logic [`APB_DATA_WIDTH-1:0] prdata;
    } apb_rsp_t;

    // Register map, RAT window holds one word per logical register
    typedef enum logic [`APB_ADDR_WIDTH-1:0] {
        CTRL         = 8'h00,
        FREE_COUNT   = 8'h04,
        COMMIT_COUNT = 8'h08,
        RAT_BASE     = 8'h80
    } csr_addr_e;

endpackage

`default_nettype wire

// ==== design/arch_rat.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rename_macros.svh"

module arch_rat (
    input  wire                  clock,
    input  wire                  reset_n,

    // Retiring slots, slot 1 is younger
    input  rename_pkg::commit_t  commit0,
    input  rename_pkg::commit_t  commit1,

    // Lookup for the register block
    input  rename_pkg::lreg_t    rat_rd_lreg,
    output rename_pkg::preg_t    rat_rd_preg,

    // Registers released by the commits
    output logic                 free0_valid,
    output logic                 free1_valid,
    output rename_pkg::preg_t    free0_preg,
    output rename_pkg::preg_t    free1_preg
);

    import rename_pkg::*;

    // Committed mapping, indexed by logical register
    preg_t map_q [`NUM_LREGS];

    logic wr0;
    logic wr1;
    logic same_lrd;

    ////////////////////////////////////////////////////////////
    // Released registers
    ////////////////////////////////////////////////////////////

    assign wr0 = commit0.valid && commit0.need_to_wb;
    assign wr1 = commit1.valid && commit1.need_to_wb;

    // Both slots retire into the same destination
    assign same_lrd = wr0 && wr1 && (commit0.lrd == commit1.lrd);

    assign free0_valid = wr0;
    assign free0_preg  = map_q[commit0.lrd];

    // Slot 1 replaces what slot 0 just installed
    assign free1_valid = wr1;
    assign free1_preg  = same_lrd ? commit0.prd : map_q[commit1.lrd];

    ////////////////////////////////////////////////////////////
    // Table update
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset_n) begin
        if (reset_n) begin
            // Identity mapping
            for (int i = 0; i < `NUM_LREGS; i++) begin
                map_q[i] <= preg_t'(i);
            end
        end else begin
            if (wr0) begin
                map_q[commit0.lrd] <= commit0.prd;
            end
            // Later assignment wins on a shared lrd
            if (wr1) begin
                map_q[commit1.lrd] <= commit1.prd;
            end
        end
    end

    // Read port, no bypass needed since reads lag commits by a cycle
    assign rat_rd_preg = map_q[rat_rd_lreg];

endmodule

`default_nettype wire

// ==== design/preg_free_list.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rename_macros.svh"

module preg_free_list (
    input  wire                         clock,
    input  wire                         reset_n,

    // Returns from the table
    input  wire                         free0_valid,
    input  wire                         free1_valid,
    input  rename_pkg::preg_t           free0_preg,
    input  rename_pkg::preg_t           free1_preg,

    // Allocation toward rename
    input  wire                         alloc_req,
    output logic                        alloc_valid,
    output rename_pkg::preg_t           alloc_preg,

    output logic [`FREE_CNT_WIDTH-1:0]  free_count
);

    import rename_pkg::*;

    localparam int DEPTH = `FREE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = `FREE_CNT_WIDTH;

    preg_t            mem_q [DEPTH];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;

    logic             pop;
    logic [1:0]       push_cnt;
    logic [PTR_W-1:0] wr1_ptr;

    ////////////////////////////////////////////////////////////
    // Pointer control
    ////////////////////////////////////////////////////////////

    assign pop      = alloc_req && alloc_valid;
    assign push_cnt = {1'b0, free0_valid} + {1'b0, free1_valid};

    // Port 1 lands behind port 0 when both push
    assign wr1_ptr = free0_valid ? tail_q + PTR_W'(1) : tail_q;

    always_ff @(posedge clock or posedge reset_n) begin
        if (reset_n) begin
            // Full, holding every register above the identity map
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= preg_t'(i + `NUM_LREGS);
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= CNT_W'(DEPTH);
        end else begin
            if (free0_valid) begin
                mem_q[tail_q] <= free0_preg;
            end
            if (free1_valid) begin
                mem_q[wr1_ptr] <= free1_preg;
            end
            tail_q  <= tail_q + PTR_W'(push_cnt);
            head_q  <= head_q + PTR_W'(pop);
            count_q <= count_q + CNT_W'(push_cnt) - CNT_W'(pop);
        end
    end

    ////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////

    // Head entry, zero latency
    assign alloc_preg  = mem_q[head_q];
    assign alloc_valid = (count_q != '0);
    assign free_count  = count_q;

endmodule

`default_nettype wire

// ==== design/rat_csr.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rename_macros.svh"

module rat_csr (
    input  wire                         clock,
    input  wire                         reset_n,

    input  apb_pkg::apb_req_t           apb_req,
    output apb_pkg::apb_rsp_t           apb_rsp,

    // Table lookup
    output rename_pkg::lreg_t           rat_rd_lreg,
    input  rename_pkg::preg_t           rat_rd_preg,

    input  wire [`FREE_CNT_WIDTH-1:0]   free_count,

    // One bit per slot that wrote the table
    input  wire [1:0]                   commit_writes,
    output logic                        commit_ready
);

    import apb_pkg::*;
    import rename_pkg::*;

    localparam int DATA_W = `APB_DATA_WIDTH;

    logic              freeze_q;
    logic [DATA_W-1:0] commit_cnt_q;

    logic              access;
    logic              hit_ctrl;
    logic              hit_free;
    logic              hit_commit;
    logic              hit_rat;
    logic              mapped;
    logic [DATA_W-1:0] rdata;

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////

    assign access = apb_req.psel && apb_req.penable;

    assign hit_ctrl   = (apb_req.paddr == CTRL);
    assign hit_free   = (apb_req.paddr == FREE_COUNT);
    assign hit_commit = (apb_req.paddr == COMMIT_COUNT);

    // RAT window runs to the top of the 8-bit space
    // so nothing past RAT_BASE + 128 is reachable
    assign hit_rat = (apb_req.paddr >= RAT_BASE) && (apb_req.paddr[1:0] == 2'b00);

    assign mapped = hit_ctrl || hit_free || hit_commit || hit_rat;

    // Word index inside the RAT window
    assign rat_rd_lreg = lreg_t'(apb_req.paddr[`LREG_WIDTH+1:2]);

    ////////////////////////////////////////////////////////////
    // Read data
    ////////////////////////////////////////////////////////////

    always_comb begin
        rdata = '0;
        if (hit_ctrl) begin
            rdata = DATA_W'(freeze_q);
        end else if (hit_free) begin
            rdata = DATA_W'(free_count);
        end else if (hit_commit) begin
            rdata = commit_cnt_q;
        end else if (hit_rat) begin
            rdata = DATA_W'(rat_rd_preg);
        end
    end

    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.prdata  = rdata;
    // Only CTRL is writable
    assign apb_rsp.pslverr = access && (!mapped || (apb_req.pwrite && !hit_ctrl));

    ////////////////////////////////////////////////////////////
    // Control and statistics
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset_n) begin
        if (reset_n) begin
            freeze_q     <= 1'b0;
            commit_cnt_q <= '0;
        end else begin
            // Freeze is CTRL bit 0
            if (access && apb_req.pwrite && hit_ctrl) begin
                freeze_q <= apb_req.pwdata[0];
            end
            // Wraps
            commit_cnt_q <= commit_cnt_q + DATA_W'(commit_writes[0])
                                         + DATA_W'(commit_writes[1]);
        end
    end

    assign commit_ready = !freeze_q;

endmodule

`default_nettype wire

// ==== design/rename_commit_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rename_macros.svh"

module rename_commit_top (
    input  wire                  clock,
    input  wire                  reset_n,

    // Retire interface from the ROB
    input  rename_pkg::commit_t  commit0,
    input  rename_pkg::commit_t  commit1,
    output logic                 commit_ready,

    // Allocation for the rename port
    input  wire                  alloc_req,
    output logic                 alloc_valid,
    output rename_pkg::preg_t    alloc_preg,

    input  apb_pkg::apb_req_t    apb_req,
    output apb_pkg::apb_rsp_t    apb_rsp
);

    import rename_pkg::*;

    commit_t                     commit0_acc;
    commit_t                     commit1_acc;
    logic [1:0]                  commit_writes;

    lreg_t                       rat_rd_lreg;
    preg_t                       rat_rd_preg;
    logic                        free0_valid;
    logic                        free1_valid;
    preg_t                       free0_preg;
    preg_t                       free1_preg;
    logic [`FREE_CNT_WIDTH-1:0]  free_count;

    // Hold off both slots while frozen
    always_comb begin
        commit0_acc       = commit0;
        commit1_acc       = commit1;
        commit0_acc.valid = commit0.valid && commit_ready;
        commit1_acc.valid = commit1.valid && commit_ready;
    end

    assign commit_writes = {commit1_acc.valid && commit1_acc.need_to_wb,
                            commit0_acc.valid && commit0_acc.need_to_wb};

    arch_rat arch_rat_i (
        .clock       (clock),
        .reset_n     (reset_n),
        .commit0     (commit0_acc),
        .commit1     (commit1_acc),
        .rat_rd_lreg (rat_rd_lreg),
        .rat_rd_preg (rat_rd_preg),
        .free0_valid (free0_valid),
        .free1_valid (free1_valid),
        .free0_preg  (free0_preg),
        .free1_preg  (free1_preg)
    );

    preg_free_list preg_free_list_i (
        .clock       (clock),
        .reset_n     (reset_n),
        .free0_valid (free0_valid),
        .free1_valid (free1_valid),
        .free0_preg  (free0_preg),
        .free1_preg  (free1_preg),
        .alloc_req   (alloc_req),
        .alloc_valid (alloc_valid),
        .alloc_preg  (alloc_preg),
        .free_count  (free_count)
    );

    rat_csr rat_csr_i (
        .clock         (clock),
        .reset_n       (reset_n),
        .apb_req       (apb_req),
        .apb_rsp       (apb_rsp),
        .rat_rd_lreg   (rat_rd_lreg),
        .rat_rd_preg   (rat_rd_preg),
        .free_count    (free_count),
        .commit_writes (commit_writes),
        .commit_ready  (commit_ready)
    );

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clock,
    output logic reset_n
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    // Reset is high while active, released on a falling edge
    initial begin
        reset_n = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b0;
    end

endmodule

`default_nettype wire

// ==== test/rename_commit_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rename_macros.svh"

module rename_commit_tb;

    import rename_pkg::*;
    import apb_pkg::*;

    // Cycle budgets per test summed for the watchdog
    localparam int N_RANDOM    = 40;
    localparam int READY_WAIT  = 8;
    localparam int CYC_RESET   = 4;
    localparam int CYC_T1      = 2 * (`NUM_LREGS + 3);
    localparam int CYC_T2      = N_RANDOM * 9;
    localparam int CYC_T3      = 12;
    localparam int CYC_T4      = `NUM_PREGS + 8;
    localparam int CYC_T5      = 40;
    localparam int STIM_CYCLES = CYC_RESET + CYC_T1 + CYC_T2 + CYC_T3 + CYC_T4 + CYC_T5;
    localparam int TIMEOUT_NS  = STIM_CYCLES * 10 + 500;

    logic        clock;
    logic        reset_n;
    commit_t     commit0;
    commit_t     commit1;
    logic        commit_ready;
    logic        alloc_req;
    logic        alloc_valid;
    preg_t       alloc_preg;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;

    // Reference model state
    preg_t       model_map [`NUM_LREGS];
    preg_t       model_free [$];
    preg_t       inflight [$];
    logic        model_freeze;
    int unsigned model_commits;

    // Expected outputs refreshed after every edge
    logic        exp_ready;
    logic        exp_alloc_valid;
    preg_t       exp_alloc_preg;
    logic        check_resp;
    logic        exp_slverr;
    logic        check_rdata;
    logic [31:0] exp_rdata;
    logic        last_ready;

    string       test_name;
    int          errors;
    int          test_base;
    int          tests_run;
    int          tests_bad;

    tb_clock_gen clock_gen_i (
        .clock   (clock),
        .reset_n (reset_n)
    );

    rename_commit_top dut_i (
        .clock        (clock),
        .reset_n      (reset_n),
        .commit0      (commit0),
        .commit1      (commit1),
        .commit_ready (commit_ready),
        .alloc_req    (alloc_req),
        .alloc_valid  (alloc_valid),
        .alloc_preg   (alloc_preg),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp)
    );

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    function automatic void record_mismatch(input string what, input logic [31:0] expected,
                                            input logic [31:0] actual);
        errors++;
        $display("FAILED %s: %s expected 0x%0h actual 0x%0h at %0t",
                 test_name, what, expected, actual, $time);
    endfunction

    ready_check: assert property (@(posedge clock) disable iff (reset_n)
        commit_ready == exp_ready)
        else record_mismatch("commit_ready", 32'($sampled(exp_ready)),
                             32'($sampled(commit_ready)));

    alloc_valid_check: assert property (@(posedge clock) disable iff (reset_n)
        alloc_valid == exp_alloc_valid)
        else record_mismatch("alloc_valid", 32'($sampled(exp_alloc_valid)),
                             32'($sampled(alloc_valid)));

    alloc_preg_check: assert property (@(posedge clock) disable iff (reset_n)
        exp_alloc_valid |-> (alloc_preg == exp_alloc_preg))
        else record_mismatch("alloc_preg", 32'($sampled(exp_alloc_preg)),
                             32'($sampled(alloc_preg)));

    pready_check: assert property (@(posedge clock) disable iff (reset_n)
        check_resp |-> apb_rsp.pready)
        else record_mismatch("pready", 32'd1, 32'($sampled(apb_rsp.pready)));

    slverr_check: assert property (@(posedge clock) disable iff (reset_n)
        check_resp |-> (apb_rsp.pslverr == exp_slverr))
        else record_mismatch("pslverr", 32'($sampled(exp_slverr)),
                             32'($sampled(apb_rsp.pslverr)));

    rdata_check: assert property (@(posedge clock) disable iff (reset_n)
        check_rdata |-> (apb_rsp.prdata == exp_rdata))
        else record_mismatch("prdata", $sampled(exp_rdata), $sampled(apb_rsp.prdata));

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic void refresh_expect();
        exp_ready       = !model_freeze;
        exp_alloc_valid = (model_free.size() != 0);
        exp_alloc_preg  = exp_alloc_valid ? model_free[0] : '0;
    endfunction

    function automatic void model_reset();
        for (int i = 0; i < `NUM_LREGS; i++) begin
            model_map[i] = preg_t'(i);
        end
        model_free.delete();
        for (int i = `NUM_LREGS; i < `NUM_PREGS; i++) begin
            model_free.push_back(preg_t'(i));
        end
        model_freeze  = 1'b0;
        model_commits = 0;
        refresh_expect();
    endfunction

    function automatic logic model_mapped(input logic [7:0] addr);
        if (addr == CTRL || addr == FREE_COUNT || addr == COMMIT_COUNT) begin
            return 1'b1;
        end
        return (addr >= 8'h80) && (addr[1:0] == 2'b00);
    endfunction

    function automatic logic [31:0] model_read(input logic [7:0] addr);
        if (addr == CTRL) begin
            return {31'b0, model_freeze};
        end else if (addr == FREE_COUNT) begin
            return 32'(model_free.size());
        end else if (addr == COMMIT_COUNT) begin
            return model_commits;
        end else if (model_mapped(addr)) begin
            return 32'(model_map[addr[6:2]]);
        end
        return '0;
    endfunction

    // Retire one slot in program order
    // Old mapping goes back to the free list
    function automatic void model_retire(input commit_t c);
        if (c.valid && c.need_to_wb && !model_freeze) begin
            model_free.push_back(model_map[c.lrd]);
            model_map[c.lrd] = c.prd;
            model_commits++;
        end
    endfunction

    function automatic void model_update(input commit_t c0, input commit_t c1,
                                         input logic areq, input apb_req_t req);
        if (areq && model_free.size() != 0) begin
            inflight.push_back(model_free.pop_front());
        end
        model_retire(c0);
        model_retire(c1);
        if (req.psel && req.penable && req.pwrite && req.paddr == CTRL) begin
            model_freeze = req.pwdata[0];
        end
        refresh_expect();
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    function automatic commit_t make_commit(input lreg_t lrd, input preg_t prd, input logic wb);
        commit_t c;
        c.valid      = 1'b1;
        c.need_to_wb = wb;
        c.lrd        = lrd;
        c.prd        = prd;
        return c;
    endfunction

    function automatic logic [7:0] rat_addr(input lreg_t lrd);
        return {1'b1, lrd, 2'b00};
    endfunction

    // Inputs change on the falling edge
    // Model follows the rising edge
    task automatic drive_cycle(input commit_t c0, input commit_t c1, input logic areq,
                               input apb_req_t req);
        @(negedge clock);
        commit0     = c0;
        commit1     = c1;
        alloc_req   = areq;
        apb_req     = req;
        last_ready  = commit_ready;
        check_resp  = req.psel && req.penable;
        exp_slverr  = !model_mapped(req.paddr) || (req.pwrite && req.paddr != CTRL);
        check_rdata = check_resp && !req.pwrite && model_mapped(req.paddr);
        exp_rdata   = model_read(req.paddr);
        @(posedge clock);
        model_update(c0, c1, areq, req);
    endtask

    task automatic idle_cycle();
        drive_cycle('0, '0, 1'b0, '0);
    endtask

    task automatic alloc_one();
        drive_cycle('0, '0, 1'b1, '0);
    endtask

    task automatic apb_access(input logic [7:0] addr, input logic write, input logic [31:0] data);
        apb_req_t req;
        req        = '0;
        req.psel   = 1'b1;
        req.pwrite = write;
        req.paddr  = addr;
        req.pwdata = data;
        drive_cycle('0, '0, 1'b0, req);
        req.penable = 1'b1;
        drive_cycle('0, '0, 1'b0, req);
    endtask

    task automatic apb_read(input logic [7:0] addr);
        apb_access(addr, 1'b0, '0);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_base = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == test_base) begin
            $display("Test %0d %s: ok", tests_run, test_name);
        end else begin
            tests_bad++;
            $display("Test %0d %s: %0d checks failed", tests_run, test_name, errors - test_base);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    initial begin
        lreg_t lrd;
        lreg_t lrd_b;
        preg_t prd_a;
        preg_t prd_b;
        logic  wb;
        int    tries;

        commit0     = '0;
        commit1     = '0;
        alloc_req   = 1'b0;
        apb_req     = '0;
        check_resp  = 1'b0;
        check_rdata = 1'b0;
        exp_slverr  = 1'b0;
        exp_rdata   = '0;
        last_ready  = 1'b0;
        errors      = 0;
        tests_run   = 0;
        tests_bad   = 0;
        void'($urandom(32'hc8ed));
        model_reset();
        @(negedge reset_n);

        start_test("reset_state");
        for (int i = 0; i < `NUM_LREGS; i++) begin
            apb_read(rat_addr(lreg_t'(i)));
        end
        apb_read(FREE_COUNT);
        apb_read(COMMIT_COUNT);
        apb_read(CTRL);
        finish_test();

        start_test("random_commits");
        for (int n = 0; n < N_RANDOM; n++) begin
            lrd = lreg_t'($urandom_range(`NUM_LREGS - 1));
            wb  = ($urandom_range(3) != 0);
            if (wb) begin
                alloc_one();
                drive_cycle(make_commit(lrd, inflight.pop_front(), 1'b1), '0, 1'b0, '0);
            end else begin
                drive_cycle(make_commit(lrd, preg_t'($urandom), 1'b0), '0, 1'b0, '0);
            end
            apb_read(rat_addr(lrd));
            apb_read(FREE_COUNT);
            apb_read(COMMIT_COUNT);
        end
        finish_test();

        // Both slots retire into one logical register
        start_test("same_lreg_pair");
        lrd = lreg_t'($urandom_range(`NUM_LREGS - 1));
        alloc_one();
        alloc_one();
        prd_a = inflight.pop_front();
        prd_b = inflight.pop_front();
        drive_cycle(make_commit(lrd, prd_a, 1'b1), make_commit(lrd, prd_b, 1'b1), 1'b0, '0);
        apb_read(rat_addr(lrd));
        apb_read(FREE_COUNT);
        apb_read(COMMIT_COUNT);
        finish_test();

        // Drain includes the two returns from the pair above
        start_test("alloc_fifo_order");
        while (model_free.size() != 0) begin
            alloc_one();
        end
        alloc_one();
        apb_read(FREE_COUNT);
        finish_test();

        start_test("freeze_and_errors");
        apb_access(CTRL, 1'b1, 32'h1);
        lrd   = lreg_t'($urandom_range(`NUM_LREGS - 1));
        lrd_b = lrd ^ lreg_t'(1);
        prd_a = inflight[0];
        prd_b = inflight[1];
        // ROB keeps offering both slots while frozen
        repeat (3) begin
            drive_cycle(make_commit(lrd, prd_a, 1'b1), make_commit(lrd_b, prd_b, 1'b1),
                        1'b0, '0);
        end
        apb_read(rat_addr(lrd));
        apb_read(rat_addr(lrd_b));
        apb_read(FREE_COUNT);
        apb_read(COMMIT_COUNT);
        apb_access(CTRL, 1'b1, 32'h0);
        tries = 0;
        do begin
            drive_cycle(make_commit(lrd, prd_a, 1'b1), make_commit(lrd_b, prd_b, 1'b1),
                        1'b0, '0);
            tries++;
        end while (!last_ready && tries < READY_WAIT);
        if (last_ready) begin
            void'(inflight.pop_front());
            void'(inflight.pop_front());
        end else begin
            errors++;
            $display("commit_ready stayed low after the freeze bit was cleared");
        end
        apb_read(rat_addr(lrd));
        apb_read(rat_addr(lrd_b));
        apb_read(8'h40);
        apb_access(FREE_COUNT, 1'b1, 32'h5);
        apb_read(FREE_COUNT);
        apb_read(COMMIT_COUNT);
        idle_cycle();
        finish_test();

        $display("Tests run %0d, tests with errors %0d, failed checks %0d",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns before the tests completed", TIMEOUT_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rename_commit.f ====
+incdir+design
design/rename_pkg.sv
design/apb_pkg.sv
design/arch_rat.sv
design/preg_free_list.sv
design/rat_csr.sv
design/rename_commit_top.sv
test/tb_clock_gen.sv
test/rename_commit_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps
TOP       := rename_commit_tb
FILELIST  := rename_commit.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation finished: PASS

.PHONY: simulate clean

# Build, run, then decide the result from the log
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
